//--- verilog.f
+incdir+.
oflow_pkg.sv
oflow_buffer_reader.sv
oflow_score_calc_fsm.sv
oflow_similarity_metric.sv
oflow_score_select.sv
oflow_score_calc.sv
tb_wb_memory.sv
tb_oflow_score_calc.sv

//--- Bender.yml
package:
  name: oflow_score_calc

sources:
  - include_dirs:
      - .
    files:
      - oflow_pkg.sv
      - oflow_buffer_reader.sv
      - oflow_score_calc_fsm.sv
      - oflow_similarity_metric.sv
      - oflow_score_select.sv
      - oflow_score_calc.sv
  - target: test
    include_dirs:
      - .
    files:
      - tb_wb_memory.sv
      - tb_oflow_score_calc.sv

//--- tb_oflow_score_calc.sv
/* score calculation testbench */

`include "oflow_params.svh"

module tb_oflow_score_calc;
	timeunit 1ns;
	timeprecision 1ps;

	localparam logic [31:0] SEED = 32'ha228_c981;
	// worst case bus cycles per word with 3 waits and the hold cycle
	localparam int WORD_WORST = 6;
	// control and metric cycles per pair plus margin
	localparam int PAIR_EXTRA = 9;
	// stray start goes out this many cycles into a run
	localparam int POKE_CYCLE = 40;
	localparam int ID_MSB = $bits(oflow_pkg::entry_t) - 1;

	logic clk;
	logic reset_N;
	logic start;
	oflow_pkg::count_t num_objects;
	oflow_pkg::feature_t cur_feature;
	logic wb_cyc;
	logic wb_stb;
	oflow_pkg::addr_t wb_adr;
	oflow_pkg::entry_t wb_rdat;
	logic wb_ack;
	logic done;
	oflow_pkg::id_t match_id;
	oflow_pkg::score_t match_score;

	oflow_pkg::entry_t image [`OFLOW_MAX_OBJECTS];
	logic [31:0] lfsr_state;
	string test_name;
	// bus monitor state
	int read_count;
	bit cyc_seen;
	logic prev_stb;
	logic prev_ack;
	oflow_pkg::addr_t prev_adr;

	always #10 clk = ~clk;

	oflow_score_calc dut (
		.clk(clk), .reset_N(reset_N), .start(start), .num_objects(num_objects),
		.cur_feature(cur_feature), .wb_cyc(wb_cyc), .wb_stb(wb_stb), .wb_adr(wb_adr),
		.wb_rdat(wb_rdat), .wb_ack(wb_ack), .done(done),
		.match_id(match_id), .match_score(match_score)
	);

	tb_wb_memory #(.SEED(SEED)) mem (
		.clk(clk), .reset_N(reset_N), .cyc(wb_cyc), .stb(wb_stb),
		.adr(wb_adr), .rdat(wb_rdat), .ack(wb_ack)
	);

	// ------------------------------------------------------------
	// helpers
	// ------------------------------------------------------------

	function automatic logic [31:0] lfsr_step(input logic [31:0] s);
		lfsr_step = s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
	endfunction

	task automatic draw_bits(input int n, output logic [31:0] v);
		v = '0;
		for (int i = 0; i < n; i++) begin
			v = {v[30:0], lfsr_state[0]};
			lfsr_state = lfsr_step(lfsr_state);
		end
	endtask

	task automatic report_failure(input string what);
		$display("%s: %s", test_name, what);
		$display("Errors found");
		$fatal(1);
	endtask

	task automatic check_value(input string what, input logic [31:0] expected,
			input logic [31:0] actual);
		assert (expected === actual) else begin
			$display("error %s %s: expected %0d, actual %0d",
				test_name, what, expected, actual);
			$display("Errors found");
			$fatal(1);
		end
	endtask

	// random words with about one slot in four empty
	task automatic fill_random();
		logic [31:0] pick;
		logic [31:0] id;
		logic [31:0] feat;
		for (int i = 0; i < `OFLOW_MAX_OBJECTS; i++) begin
			draw_bits(2, pick);
			draw_bits(`OFLOW_ID_LEN, id);
			draw_bits(`OFLOW_NUM_COMP * `OFLOW_COMP_W, feat);
			if (pick == 0) id = 0;
			image[i] = {id[`OFLOW_ID_LEN-1:0], feat[`OFLOW_NUM_COMP*`OFLOW_COMP_W-1:0]};
		end
	endtask

	task automatic load_memory();
		for (int i = 0; i < `OFLOW_MAX_OBJECTS; i++) mem.words[i] = image[i];
	endtask

	// in-order scan where a strictly lower score wins and empty ids are skipped
	task automatic compute_expected(input int n, input oflow_pkg::feature_t feat,
			output oflow_pkg::id_t exp_id, output oflow_pkg::score_t exp_score);
		int sad;
		int a;
		int b;
		exp_id = '0;
		exp_score = '1;
		for (int i = 0; i < n; i++) begin
			if (image[i][ID_MSB -: `OFLOW_ID_LEN] != 0) begin
				sad = 0;
				for (int c = 0; c < `OFLOW_NUM_COMP; c++) begin
					a = feat[c*`OFLOW_COMP_W +: `OFLOW_COMP_W];
					b = image[i][c*`OFLOW_COMP_W +: `OFLOW_COMP_W];
					sad += (a > b) ? a - b : b - a;
				end
				if (sad < exp_score) begin
					exp_id = image[i][ID_MSB -: `OFLOW_ID_LEN];
					exp_score = oflow_pkg::score_t'(sad);
				end
			end
		end
	endtask

	// one calculation with an optional stray start in mid run
	// poke needs a run of 16 or more objects
	task automatic run_calc(input string name, input int n,
			input oflow_pkg::feature_t feat, input bit poke);
		oflow_pkg::id_t exp_id;
		oflow_pkg::score_t exp_score;
		int cycles;
		int limit;
		test_name = name;
		compute_expected(n, feat, exp_id, exp_score);
		limit = 20 + n * WORD_WORST + ((n + 1) / 2) * PAIR_EXTRA;
		@(posedge clk);
		#2;
		read_count = 0;
		cyc_seen = 0;
		num_objects = oflow_pkg::count_t'(n);
		cur_feature = feat;
		start = 1'b1;
		@(posedge clk);
		#2;
		start = 1'b0;
		@(negedge clk);
		// previous result cleared by start
		check_value("cleared id", 0, match_id);
		check_value("cleared score", (1 << `OFLOW_SCORE_W) - 1, match_score);
		cycles = 0;
		while (!done) begin
			@(posedge clk);
			#2;
			start = poke && (cycles == POKE_CYCLE);
			cycles++;
			if (cycles > limit) report_failure("done did not arrive before the timeout");
			@(negedge clk);
		end
		check_value("match_id", exp_id, match_id);
		check_value("match_score", exp_score, match_score);
		check_value("words read", n, read_count);
		if (n == 0) check_value("wb_cyc raised", 0, cyc_seen);
	endtask

	// ------------------------------------------------------------
	// bus monitor
	// ------------------------------------------------------------

	always @(negedge clk) begin
		if (!reset_N) begin
			prev_stb = 1'b0;
			prev_ack = 1'b0;
			prev_adr = '0;
		end else begin
			if (wb_cyc) cyc_seen = 1'b1;
			assert (!wb_stb || wb_cyc) else report_failure("wb_stb high without wb_cyc");
			if (prev_stb && !prev_ack) begin
				assert (wb_stb && wb_adr == prev_adr)
					else report_failure("strobe or address changed before ack");
			end
			if (prev_ack) begin
				assert (!wb_cyc) else report_failure("wb_cyc still high after ack");
			end
			if (wb_cyc && wb_stb && wb_ack) begin
				check_value("read address", `OFLOW_BUF_BASE + read_count, wb_adr);
				read_count++;
			end
			prev_stb = wb_stb;
			prev_ack = wb_ack;
			prev_adr = wb_adr;
		end
	end

	// ------------------------------------------------------------
	// test sequence
	// ------------------------------------------------------------

	initial begin
		logic [31:0] feat_a;
		logic [31:0] feat_b;
		clk = 1'b0;
		reset_N = 1'b0;
		start = 1'b0;
		num_objects = '0;
		cur_feature = '0;
		lfsr_state = SEED;
		test_name = "reset";
		repeat (2) @(posedge clk);
		#2;
		reset_N = 1'b1;

		// odd count with random wait states
		fill_random();
		load_memory();
		draw_bits(24, feat_a);
		run_calc("odd_count", 13, feat_a[23:0], 1'b0);

		// index 4 ties with its pair partner 5 and with 9 later
		// lowest index wins
		draw_bits(24, feat_a);
		image[4] = {8'h21, feat_a[23:0]};
		image[5] = {8'h63, feat_a[23:0]};
		image[9] = {8'h42, feat_a[23:0]};
		load_memory();
		run_calc("tie_low_index", 11, feat_a[23:0], 1'b0);

		run_calc("zero_objects", 0, feat_a[23:0], 1'b0);

		// perfect matches in empty slots on both lanes and the odd tail
		fill_random();
		draw_bits(24, feat_a);
		image[2] = {8'h00, feat_a[23:0]};
		image[5] = {8'h00, feat_a[23:0]};
		image[8] = {8'h00, feat_a[23:0]};
		load_memory();
		run_calc("empty_slots", 9, feat_a[23:0], 1'b0);

		// full buffer with a stray start
		// perfect match at index 0 is already held when the stray start comes
		fill_random();
		draw_bits(24, feat_a);
		image[0] = {8'h5a, feat_a[23:0]};
		load_memory();
		run_calc("max_objects", `OFLOW_MAX_OBJECTS, feat_a[23:0], 1'b1);

		// back to back runs with a new feature each
		draw_bits(24, feat_a);
		draw_bits(24, feat_b);
		run_calc("back_to_back_a", 21, feat_a[23:0], 1'b0);
		image[0] = {8'h6b, feat_b[23:0]};
		load_memory();
		run_calc("back_to_back_b", 21, feat_b[23:0], 1'b1);

		$display("No errors");
		$finish;
	end

endmodule

//--- tb_wb_memory.sv
/* wishbone read slave memory model */

`include "oflow_params.svh"

module tb_wb_memory #(
	parameter logic [31:0] SEED = 32'ha228_c981
) (
	input logic clk,
	input logic reset_N,
	input logic cyc,
	input logic stb,
	input oflow_pkg::addr_t adr,
	output oflow_pkg::entry_t rdat,
	output logic ack
);
	timeunit 1ns;
	timeprecision 1ps;

	// object words, loaded by the testbench top
	oflow_pkg::entry_t words [`OFLOW_MAX_OBJECTS];

	logic [31:0] lfsr;
	logic [31:0] lfsr_a;
	// 0 to 3 wait cycles, two lfsr bits
	logic [1:0] delay_draw;
	logic waiting;
	logic [1:0] wait_left;
	oflow_pkg::addr_t offset;

	// galois lfsr, one step per bit
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		lfsr_next = s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
	endfunction

	assign lfsr_a = lfsr_next(lfsr);
	assign delay_draw = {lfsr[0], lfsr_a[0]};
	assign offset = adr - oflow_pkg::addr_t'(`OFLOW_BUF_BASE);

	always @(posedge clk or negedge reset_N) begin
		if (!reset_N) begin
			lfsr <= SEED;
			ack <= 1'b0;
			waiting <= 1'b0;
			wait_left <= '0;
			rdat <= '0;
		end else begin
			ack <= 1'b0;
			if (cyc && stb && !ack) begin
				if (!waiting) begin
					// new request, draw its delay
					lfsr <= lfsr_next(lfsr_a);
					if (delay_draw == 2'd0) begin
						ack <= 1'b1;
						rdat <= words[offset[$clog2(`OFLOW_MAX_OBJECTS)-1:0]];
					end else begin
						waiting <= 1'b1;
						wait_left <= delay_draw - 2'd1;
					end
				end else if (wait_left == 2'd0) begin
					waiting <= 1'b0;
					ack <= 1'b1;
					rdat <= words[offset[$clog2(`OFLOW_MAX_OBJECTS)-1:0]];
				end else begin
					wait_left <= wait_left - 2'd1;
				end
			end
		end
	end

endmodule

//--- oflow_score_calc.sv
/* object tracker score calculation top */

`include "oflow_params.svh"

module oflow_score_calc (
	input logic clk,
	input logic reset_N,
	input logic start,
	input oflow_pkg::count_t num_objects,
	// stable from start until done
	input oflow_pkg::feature_t cur_feature,
	// wishbone classic read master
	output logic wb_cyc,
	output logic wb_stb,
	output oflow_pkg::addr_t wb_adr,
	input oflow_pkg::entry_t wb_rdat,
	input logic wb_ack,
	// result, valid from done until next start
	output logic done,
	output oflow_pkg::id_t match_id,
	output oflow_pkg::score_t match_score
);

	// ------------------------------------------------------------
	// internal wires
	// ------------------------------------------------------------

	logic fetch_pair;
	logic pair_ready;
	logic done_read;
	oflow_pkg::entry_t entry_0;
	oflow_pkg::entry_t entry_1;
	oflow_pkg::id_t id_0;
	oflow_pkg::id_t id_1;
	logic start_metric_0;
	logic start_metric_1;
	oflow_pkg::score_t score_0;
	oflow_pkg::score_t score_1;
	logic metric_done_0;
	logic metric_done_1;

	// id sits in the top byte of each entry
	assign id_0 = entry_0[$bits(oflow_pkg::entry_t)-1 -: `OFLOW_ID_LEN];
	assign id_1 = entry_1[$bits(oflow_pkg::entry_t)-1 -: `OFLOW_ID_LEN];

	// ------------------------------------------------------------
	// fetch and control
	// ------------------------------------------------------------

	oflow_buffer_reader u_reader (
		.clk(clk), .reset_N(reset_N), .start(start), .fetch_pair(fetch_pair),
		.num_objects(num_objects), .wb_rdat(wb_rdat), .wb_ack(wb_ack),
		.wb_cyc(wb_cyc), .wb_stb(wb_stb), .wb_adr(wb_adr),
		.entry_0(entry_0), .entry_1(entry_1),
		.pair_ready(pair_ready), .done_read(done_read)
	);

	// lane 0 completion paces the fsm
	oflow_score_calc_fsm u_fsm (
		.clk(clk), .reset_N(reset_N), .start(start),
		.pair_ready(pair_ready), .done_read(done_read), .id_1(id_1),
		.done_similarity_metric(metric_done_0),
		.fetch_pair(fetch_pair), .start_metric_0(start_metric_0),
		.start_metric_1(start_metric_1), .done(done)
	);

	// ------------------------------------------------------------
	// metric lanes and selector
	// ------------------------------------------------------------

	oflow_similarity_metric metric_0 (
		.clk(clk), .reset_N(reset_N), .start_metric(start_metric_0),
		.cur_feature(cur_feature), .entry(entry_0),
		.score(score_0), .metric_done(metric_done_0)
	);

	oflow_similarity_metric metric_1 (
		.clk(clk), .reset_N(reset_N), .start_metric(start_metric_1),
		.cur_feature(cur_feature), .entry(entry_1),
		.score(score_1), .metric_done(metric_done_1)
	);

	oflow_score_select u_select (
		.clk(clk), .reset_N(reset_N), .start(start), .done(done),
		.metric_done_0(metric_done_0), .metric_done_1(metric_done_1),
		.score_0(score_0), .score_1(score_1), .id_0(id_0), .id_1(id_1),
		.match_id(match_id), .match_score(match_score)
	);

endmodule

//--- oflow_score_select.sv
/* best score selector */

module oflow_score_select (
	input logic clk,
	input logic reset_N,
	input logic start,
	// end of run, frees the selector for the next start
	input logic done,
	input logic metric_done_0,
	input logic metric_done_1,
	input oflow_pkg::score_t score_0,
	input oflow_pkg::score_t score_1,
	input oflow_pkg::id_t id_0,
	input oflow_pkg::id_t id_1,
	output oflow_pkg::id_t match_id,
	output oflow_pkg::score_t match_score
);

	// run in progress, start ignored meanwhile
	logic busy;
	logic accept;
	// best after lane 0, then after lane 1
	oflow_pkg::id_t id_a;
	oflow_pkg::score_t score_a;
	oflow_pkg::id_t id_b;
	oflow_pkg::score_t score_b;

	// a start in the done cycle opens the next run
	assign accept = start && (!busy || done);

	// ------------------------------------------------------------
	// compare chain, lane 0 first, strictly lower wins
	// ------------------------------------------------------------

	always_comb begin
		id_a = match_id;
		score_a = match_score;
		// empty slots never match
		if (metric_done_0 && (id_0 != '0) && (score_0 < match_score)) begin
			id_a = id_0;
			score_a = score_0;
		end
		id_b = id_a;
		score_b = score_a;
		if (metric_done_1 && (id_1 != '0) && (score_1 < score_a)) begin
			id_b = id_1;
			score_b = score_1;
		end
	end

	// ------------------------------------------------------------
	// result registers
	// ------------------------------------------------------------

	always_ff @(posedge clk or negedge reset_N) begin
		if (!reset_N) begin
			busy <= 1'b0;
			match_id <= '0;
			match_score <= '1;
		end else if (accept) begin
			busy <= 1'b1;
			match_id <= '0;
			match_score <= '1;
		end else begin
			if (done) busy <= 1'b0;
			match_id <= id_b;
			match_score <= score_b;
		end
	end

endmodule

//--- oflow_similarity_metric.sv
/* similarity metric lane, sum of absolute differences */

`include "oflow_params.svh"

module oflow_similarity_metric (
	input logic clk,
	input logic reset_N,
	input logic start_metric,
	input oflow_pkg::feature_t cur_feature,
	input oflow_pkg::entry_t entry,
	output oflow_pkg::score_t score,
	output logic metric_done
);

	localparam int IDX_W = $clog2(`OFLOW_NUM_COMP);
	localparam int LAST = `OFLOW_NUM_COMP - 1;

	// ------------------------------------------------------------
	// registers and wires
	// ------------------------------------------------------------

	// stored feature held for the later components
	oflow_pkg::feature_t feat_q;
	oflow_pkg::feature_t feat_src;
	// next component to add
	logic [IDX_W-1:0] comp_idx;
	logic [IDX_W-1:0] sel_idx;
	logic busy;
	oflow_pkg::comp_t stored_c;
	oflow_pkg::comp_t cur_c;
	oflow_pkg::comp_t abs_diff;

	// component 0 comes straight from the entry on start
	assign feat_src = start_metric ?
		entry[`OFLOW_NUM_COMP*`OFLOW_COMP_W-1:0] : feat_q;
	assign sel_idx = start_metric ? '0 : comp_idx;
	assign stored_c = feat_src[sel_idx*`OFLOW_COMP_W +: `OFLOW_COMP_W];
	assign cur_c = cur_feature[sel_idx*`OFLOW_COMP_W +: `OFLOW_COMP_W];
	assign abs_diff = (cur_c > stored_c) ? (cur_c - stored_c) : (stored_c - cur_c);

	// ------------------------------------------------------------
	// sequencing, done 3 cycles after start
	// ------------------------------------------------------------

	always_ff @(posedge clk or negedge reset_N) begin
		if (!reset_N) begin
			busy <= 1'b0;
			comp_idx <= '0;
			metric_done <= 1'b0;
		end else begin
			metric_done <= 1'b0;
			if (start_metric) begin
				busy <= 1'b1;
				comp_idx <= IDX_W'(1);
			end else if (busy) begin
				if (comp_idx == IDX_W'(LAST)) begin
					busy <= 1'b0;
					metric_done <= 1'b1;
				end else begin
					comp_idx <= comp_idx + 1'b1;
				end
			end
		end
	end

	// ------------------------------------------------------------
	// accumulator
	// ------------------------------------------------------------

	always_ff @(posedge clk) begin
		if (start_metric) begin
			feat_q <= entry[`OFLOW_NUM_COMP*`OFLOW_COMP_W-1:0];
			score <= oflow_pkg::score_t'(abs_diff);
		end else if (busy) begin
			score <= score + oflow_pkg::score_t'(abs_diff);
		end
	end

endmodule

//--- oflow_score_calc_fsm.sv
/* score calculation control fsm */

module oflow_score_calc_fsm (
	input logic clk,
	input logic reset_N,
	input logic start,
	// buffer reader
	input logic pair_ready,
	input logic done_read,
	input oflow_pkg::id_t id_1,
	// lane 0 completion
	input logic done_similarity_metric,
	output logic fetch_pair,
	output logic start_metric_0,
	output logic start_metric_1,
	output logic done
);

	// ------------------------------------------------------------
	// state
	// ------------------------------------------------------------

	oflow_pkg::calc_state_t cur_state;
	oflow_pkg::calc_state_t next_state;
	// pair arrived, lanes go next cycle
	logic go_metric;

	always_ff @(posedge clk or negedge reset_N) begin
		if (!reset_N) cur_state <= oflow_pkg::idle_st;
		else cur_state <= next_state;
	end

	// ------------------------------------------------------------
	// next state
	// ------------------------------------------------------------

	always_comb begin
		next_state = cur_state;
		case (cur_state)
			oflow_pkg::idle_st: begin
				// start only counts here
				if (start) next_state = oflow_pkg::fetch_st;
			end
			oflow_pkg::fetch_st: begin
				// wait on the bus, any number of cycles
				if (done_read) next_state = oflow_pkg::idle_st;
				else if (pair_ready) next_state = oflow_pkg::metric_st;
			end
			oflow_pkg::metric_st: begin
				// lanes finish together, lane 0 is enough
				if (done_similarity_metric) next_state = oflow_pkg::fetch_st;
			end
			default: next_state = oflow_pkg::idle_st;
		endcase
	end

	assign go_metric = (cur_state == oflow_pkg::fetch_st) &&
		(next_state == oflow_pkg::metric_st);

	// ------------------------------------------------------------
	// registered pulses, one cycle after the event
	// ------------------------------------------------------------

	always_ff @(posedge clk or negedge reset_N) begin
		if (!reset_N) begin
			fetch_pair <= 1'b0;
			start_metric_0 <= 1'b0;
			start_metric_1 <= 1'b0;
			done <= 1'b0;
		end else begin
			// first pair after start, next pair after lane 0
			fetch_pair <= (cur_state == oflow_pkg::idle_st && start) ||
				(cur_state == oflow_pkg::metric_st && done_similarity_metric);
			start_metric_0 <= go_metric;
			// empty second slot leaves lane 1 idle
			start_metric_1 <= go_metric && (id_1 != '0);
			done <= (cur_state == oflow_pkg::fetch_st) && done_read;
		end
	end

endmodule

//--- oflow_buffer_reader.sv
/* stored object pair reader, wishbone read master */

`include "oflow_params.svh"

module oflow_buffer_reader (
	input logic clk,
	input logic reset_N,
	input logic start,
	input logic fetch_pair,
	input oflow_pkg::count_t num_objects,
	// wishbone classic, read only
	input oflow_pkg::entry_t wb_rdat,
	input logic wb_ack,
	output logic wb_cyc,
	output logic wb_stb,
	output oflow_pkg::addr_t wb_adr,
	// pair handed to the metric lanes
	output oflow_pkg::entry_t entry_0,
	output oflow_pkg::entry_t entry_1,
	output logic pair_ready,
	output logic done_read
);

	// ------------------------------------------------------------
	// registers and wires
	// ------------------------------------------------------------

	oflow_pkg::read_state_t state;
	// index of the next object to read
	oflow_pkg::count_t obj_idx;
	oflow_pkg::count_t next_idx;
	// run in progress, a start is ignored while set
	logic active;
	// 0 while reading entry_0, 1 for entry_1
	logic slot;
	// object after the current one exists
	logic more_left;
	oflow_pkg::addr_t word_addr;
	logic word_in;

	// single word cycles, stb always follows cyc
	assign wb_stb = wb_cyc;

	assign next_idx = obj_idx + 1'b1;
	assign more_left = (next_idx < num_objects);
	assign word_addr = oflow_pkg::addr_t'(`OFLOW_BUF_BASE) + oflow_pkg::addr_t'(obj_idx);
	// slave returned the word this cycle
	assign word_in = (state == oflow_pkg::rd_bus) && wb_ack;

	// ------------------------------------------------------------
	// run flag, object index and bus fsm
	// ------------------------------------------------------------

	always_ff @(posedge clk or negedge reset_N) begin
		if (!reset_N) begin
			state <= oflow_pkg::rd_idle;
			obj_idx <= '0;
			active <= 1'b0;
			slot <= 1'b0;
			wb_cyc <= 1'b0;
			wb_adr <= '0;
			pair_ready <= 1'b0;
			done_read <= 1'b0;
		end else begin
			pair_ready <= 1'b0;
			done_read <= 1'b0;
			// new run rewinds to object 0
			if (start && !active) begin
				active <= 1'b1;
				obj_idx <= '0;
			end else if (done_read) begin
				active <= 1'b0;
			end
			case (state)
				oflow_pkg::rd_idle: begin
					if (fetch_pair) begin
						if (obj_idx >= num_objects) begin
							// buffer exhausted
							done_read <= 1'b1;
						end else begin
							wb_cyc <= 1'b1;
							wb_adr <= word_addr;
							slot <= 1'b0;
							state <= oflow_pkg::rd_bus;
						end
					end
				end
				oflow_pkg::rd_bus: begin
					// address held until ack, cyc drops after it
					if (wb_ack) begin
						wb_cyc <= 1'b0;
						obj_idx <= next_idx;
						if (!slot && more_left) begin
							state <= oflow_pkg::rd_hold;
						end else begin
							pair_ready <= 1'b1;
							state <= oflow_pkg::rd_idle;
						end
					end
				end
				oflow_pkg::rd_hold: begin
					// bus released one cycle, second word
					wb_cyc <= 1'b1;
					wb_adr <= word_addr;
					slot <= 1'b1;
					state <= oflow_pkg::rd_bus;
				end
				default: state <= oflow_pkg::rd_idle;
			endcase
		end
	end

	// ------------------------------------------------------------
	// entry slots
	// ------------------------------------------------------------

	always_ff @(posedge clk) begin
		if (word_in && slot) entry_1 <= wb_rdat;
		if (word_in && !slot) begin
			entry_0 <= wb_rdat;
			// odd tail, second slot reported empty
			if (!more_left) entry_1 <= '0;
		end
	end

endmodule

//--- oflow_pkg.sv
/* object tracker score stage types */

`include "oflow_params.svh"

package oflow_pkg;

	// ------------------------------------------------------------
	// vector types
	// ------------------------------------------------------------

	// one feature component
	typedef logic [`OFLOW_COMP_W-1:0] comp_t;
	// packed components, component 0 in the low byte
	typedef logic [`OFLOW_NUM_COMP*`OFLOW_COMP_W-1:0] feature_t;
	// object id, 0 is an empty slot
	typedef logic [`OFLOW_ID_LEN-1:0] id_t;
	// sum of absolute differences
	typedef logic [`OFLOW_SCORE_W-1:0] score_t;
	// word address on the read bus
	typedef logic [`OFLOW_ADDR_W-1:0] addr_t;
	// object count, room for the maximum itself
	typedef logic [$clog2(`OFLOW_MAX_OBJECTS+1)-1:0] count_t;
	// memory word: id on top, feature below it
	typedef logic [`OFLOW_ID_LEN+`OFLOW_NUM_COMP*`OFLOW_COMP_W-1:0] entry_t;

	// ------------------------------------------------------------
	// state machines
	// ------------------------------------------------------------

	// control fsm
	typedef enum logic [1:0] {idle_st, fetch_st, metric_st} calc_state_t;
	// buffer reader bus fsm
	typedef enum logic [1:0] {rd_idle, rd_bus, rd_hold} read_state_t;

endpackage

//--- oflow_params.svh
/* object tracker score stage parameters */

`ifndef OFLOW_PARAMS_SVH
`define OFLOW_PARAMS_SVH

// ------------------------------------------------------------
// feature layout
// ------------------------------------------------------------

// bits per feature component
`define OFLOW_COMP_W 8
// components per feature
`define OFLOW_NUM_COMP 3
// object id width, id 0 marks an empty slot
`define OFLOW_ID_LEN 8
// three differences of up to 255 need 10 bits
`define OFLOW_SCORE_W 10

// ------------------------------------------------------------
// object buffer in external memory
// ------------------------------------------------------------

// word address width on the read bus
`define OFLOW_ADDR_W 16
// word address of stored object 0
`define OFLOW_BUF_BASE 16'h0400
// largest object count per frame
`define OFLOW_MAX_OBJECTS 64

`endif
